/* vlog.f */
+incdir+verilog
verilog/board_pkg.sv
verilog/i2s_timing_if.sv
verilog/i2s_clock_timer.sv
verilog/i2s_frame_fsm.sv
verilog/inmp441_mic_receiver.sv
verilog/i2s_audio_tx.sv
verilog/loopback_lab.sv
verilog/seven_seg_latch.sv
verilog/board_top.sv
bench/tb_board_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_board_top -o tb_board_top_sim

# Pipe status comes from tee so the log decides the result
./obj_dir/tb_board_top_sim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"

/* bench/tb_board_top.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module tb_board_top;

    localparam int CLK_NS      = 100;
    localparam int SLOT        = `I2S_SLOT_BITS;
    localparam int FRAME       = 2 * `I2S_SLOT_BITS;
    localparam int FRAME_CLKS  = FRAME * 2 * `I2S_SCK_HALF;      // 1024 clk
    localparam int STIM_BIT    = SLOT + SLOT / 2;                 // Far from load and capture
    localparam int HEX_WAIT    = 27;                              // clk after the capture fall
    localparam int RUN_FRAMES  = 13;
    localparam int WATCHDOG_NS = (RUN_FRAMES + 3) * FRAME_CLKS * CLK_NS;

    logic       clk;
    logic       rst;
    logic [1:0] key;                 // Active low buttons
    logic [2:0] sw;
    logic       mic_sd;
    logic       sck;
    logic       ws;
    logic       spk_sdata;
    logic [7:0] hex0;
    logic [7:0] hex1;
    logic [7:0] hex2;
    logic [7:0] hex3;
    logic [7:0] hex4;
    logic [7:0] hex5;
    logic [7:0] hex_out [`DIGITS];

    // Reference model state
    integer      seed;
    logic [31:0] rnd;
    int          tb_bit;             // Frame position counted from sck falls
    int          frame_no;           // frame_starts since the last reset
    int          hex_wait;           // -1 when no display check pending
    int          sck_clks;           // clk since the last sck edge, -1 before the first
    logic        sck_prev;
    logic        reset_request;
    logic        mid_reset_done;
    logic        done;
    logic [23:0] cur_sample;         // Word the mic model is sending
    logic [23:0] mic_exp;
    logic [23:0] disp_exp;
    logic [15:0] word_exp;           // Word in both slots of this frame

    board_top UUT
    (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .sw        (sw),
        .sck       (sck),
        .ws        (ws),
        .mic_sd    (mic_sd),
        .spk_sdata (spk_sdata),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

    assign hex_out[0] = hex0;
    assign hex_out[1] = hex1;
    assign hex_out[2] = hex2;
    assign hex_out[3] = hex3;
    assign hex_out[4] = hex4;
    assign hex_out[5] = hex5;

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        report_problem("Timeout, the test sequence did not complete");
    end

    // --------------------
    // Error reporting

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("** Error at %0t: %s", $time, what);
        stop_with_failure();
    endtask

    // ws only moves together with a falling sck
    a_ws_on_fall: assert property (@(posedge clk) disable iff (rst) !$stable(ws) |-> $fell(sck))
        else report_problem("ws changed away from an sck falling edge");

    // --------------------
    // Expected values

    // Board code for one hex digit, segment a in bit 0, active low
    function automatic logic [7:0] segment_code(input logic [3:0] nibble);
        string      lit;
        logic [7:0] code;
        case (nibble)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'ha: lit = "abcefg";
            4'hb: lit = "cdefg";
            4'hc: lit = "adef";
            4'hd: lit = "bcdeg";
            4'he: lit = "adefg";
            default: lit = "aefg";
        endcase
        code = 8'hff;                                // Every segment dark
        for (int i = 0; i < lit.len(); i++)
            code[int'(lit[i]) - 97] = 1'b0;          // ASCII a lands on bit 0
        return code;
    endfunction

    function automatic logic [15:0] expected_word(input logic [23:0] sample,
                                                  input logic [2:0] shift,
                                                  input logic [1:0] keys);
        logic signed [15:0] top;
        top = sample[`MIC_BITS - 1 -: `SOUND_BITS];
        if (!keys[1])
            return '0;                               // Mute pressed
        return top >>> shift;
    endfunction

    // --------------------
    // Checks

    task automatic check_reset_outputs(input logic hex_too);
        if (hex_too)
        begin
            for (int d = 0; d < `DIGITS; d++)
                a_hex_off: assert (hex_out[d] == 8'hff)
                    else report_mismatch($sformatf("hex%0d", d), 32'hff, 32'(hex_out[d]));
        end
        a_sck_low: assert (sck == 1'b0) else report_mismatch("sck", 0, 32'(sck));
        a_ws_low: assert (ws == 1'b0) else report_mismatch("ws", 0, 32'(ws));
        a_sdata_low: assert (spk_sdata == 1'b0)
            else report_mismatch("spk_sdata", 0, 32'(spk_sdata));
    endtask

    task automatic check_display();
        logic [7:0] exp_seg;
        for (int d = 0; d < `DIGITS; d++)
        begin
            exp_seg = segment_code(disp_exp[4 * d +: 4]);     // Digit 0 is the low nibble
            a_hex_digit: assert (hex_out[d] == exp_seg)
                else report_mismatch($sformatf("hex%0d", d), 32'(exp_seg), 32'(hex_out[d]));
        end
    endtask

    // DAC view of the bit at this sck rise
    task automatic check_speaker_bit();
        int   pos;
        logic exp_bit;
        pos     = tb_bit % SLOT;
        exp_bit = (pos >= 1 && pos <= `SOUND_BITS) ? word_exp[`SOUND_BITS - pos] : 1'b0;
        a_speaker_bit: assert (spk_sdata == exp_bit)
            else report_mismatch("spk_sdata", 32'(exp_bit), 32'(spk_sdata));
    endtask

    // --------------------
    // Stimulus and mic model

    task automatic handle_fall();
        tb_bit = (tb_bit + 1) % FRAME;
        if (tb_bit == 0)
        begin
            frame_no   = frame_no + 1;
            word_exp   = expected_word(mic_exp, sw, key);     // Loaded at frame_start
            rnd        = $random(seed);
            cur_sample = rnd[23:0];
        end
        if (tb_bit == SLOT && frame_no > 0)                   // No capture before a full frame
        begin
            mic_exp  = cur_sample;
            hex_wait = HEX_WAIT;
        end
        mic_sd = (tb_bit >= 1 && tb_bit <= `MIC_BITS) ? cur_sample[`MIC_BITS - tb_bit] : 1'b0;

        if (tb_bit == STIM_BIT && !mid_reset_done)
        begin
            case (frame_no)
                3, 4:
                begin
                    rnd = $random(seed);
                    sw  = rnd[2:0];                  // Attenuation sweep
                end
                5: key[1] = 1'b0;                    // Mute
                6:
                begin
                    key[1] = 1'b1;
                    key[0] = 1'b0;                   // Freeze display
                end
                8: key[0] = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic track_step();
        logic exp_ws;
        if (sck == sck_prev)
        begin
            if (sck_clks >= 0)
                sck_clks = sck_clks + 1;
        end
        else
        begin
            if (sck_clks >= 0)
            begin
                a_sck_half: assert (sck_clks + 1 == `I2S_SCK_HALF)
                    else report_mismatch("sck half period", `I2S_SCK_HALF, 32'(sck_clks + 1));
            end
            sck_clks = 0;
        end

        if (sck_prev && !sck)
            handle_fall();
        else if (!sck_prev && sck)
            check_speaker_bit();
        sck_prev = sck;

        exp_ws = (tb_bit >= SLOT);                   // Right slot
        a_ws_slot: assert (ws == exp_ws) else report_mismatch("ws", 32'(exp_ws), 32'(ws));

        if (key[0])
            disp_exp = mic_exp;
        if (hex_wait > 0)
        begin
            hex_wait = hex_wait - 1;
            if (hex_wait == 0)
            begin
                check_display();
                hex_wait = -1;
            end
        end
        if (!mid_reset_done && frame_no == 9 && tb_bit == SLOT + 8)
            reset_request = 1'b1;                    // Mid right slot
    endtask

    task automatic apply_reset();
        rst    = 1'b1;
        key    = 2'b11;
        sw     = '0;
        mic_sd = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_reset_outputs(1'b1);
        end
        rst        = 1'b0;
        tb_bit     = 0;
        frame_no   = 0;
        hex_wait   = -1;
        sck_clks   = -1;
        sck_prev   = 1'b0;
        cur_sample = '0;
        mic_exp    = '0;
        disp_exp   = '0;
        word_exp   = '0;
        @(negedge clk);
        check_reset_outputs(1'b0);                   // Divider still counting
    endtask

    initial
    begin
        seed           = 32'h8090ff9f;
        reset_request  = 1'b0;
        mid_reset_done = 1'b0;
        done           = 1'b0;
        apply_reset();
        while (!done)
        begin
            @(negedge clk);
            track_step();
            if (reset_request)
            begin
                reset_request  = 1'b0;
                mid_reset_done = 1'b1;
                apply_reset();
            end
            done = mid_reset_done && frame_no == 3;
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verilog/board_top.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module board_top
    import board_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`KEY_BITS - 1:0] key,          // Active low buttons
    input  logic [`SW_BITS - 1:0]  sw,
    output logic                   sck,          // Shared by mic and DAC
    output logic                   ws,
    input  logic                   mic_sd,
    output logic                   spk_sdata,
    output logic [7:0]             hex0,
    output logic [7:0]             hex1,
    output logic [7:0]             hex2,
    output logic [7:0]             hex3,
    output logic [7:0]             hex4,
    output logic [7:0]             hex5
);

    logic [`KEY_BITS - 1:0]   lab_key;
    logic                     capture;
    logic                     load;
    logic [`MIC_BITS - 1:0]   mic_value;
    logic [`SOUND_BITS - 1:0] sound;
    seg_t                     abcdefgh;
    digit_t                   digit;

    assign lab_key = ~key;       // Pressed reads as 1 in the lab

    i2s_timing_if tim ();

    // --------------------
    // I2S side

    i2s_clock_timer i_timer (.clk(clk), .rst(rst), .tim(tim.tmr));

    i2s_frame_fsm i_frame_fsm
    (
        .clk     (clk),
        .rst     (rst),
        .tim     (tim.rx),
        .capture (capture),
        .load    (load)
    );

    inmp441_mic_receiver i_microphone
    (
        .clk       (clk),
        .rst       (rst),
        .tim       (tim.rx),
        .sd        (mic_sd),
        .capture   (capture),
        .mic_value (mic_value)
    );

    i2s_audio_tx i_audio_out
    (
        .clk   (clk),
        .rst   (rst),
        .tim   (tim.rx),
        .load  (load),
        .sound (sound),
        .sdata (spk_sdata)
    );

    assign sck = tim.sck;
    assign ws  = tim.ws;

    // --------------------
    // Lab and display

    loopback_lab i_lab
    (
        .clk       (clk),
        .rst       (rst),
        .key       (lab_key),
        .sw        (sw),
        .mic_value (mic_value),
        .sound     (sound),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    seven_seg_latch i_seg_latch
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5)
    );

endmodule

/* verilog/seven_seg_latch.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module seven_seg_latch
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  seg_t       abcdefgh,
    input  digit_t     digit,
    output logic [7:0] hex0,
    output logic [7:0] hex1,
    output logic [7:0] hex2,
    output logic [7:0] hex3,
    output logic [7:0] hex4,
    output logic [7:0] hex5
);

    seg_t hgfedcba;              // Board order, segment a in bit 0
    seg_t hex_q [`DIGITS];       // One sticky word per digit

    always_comb
    begin
        for (int i = 0; i < $bits(seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
    end

    // --------------------
    // Sticky registers

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `DIGITS; i++)
                hex_q[i] <= '1;                     // Active low, all off
        end
        else
        begin
            for (int i = 0; i < `DIGITS; i++)
                if (digit[i])
                    hex_q[i] <= ~hgfedcba;          // Holds once deselected
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(digit));

endmodule

/* verilog/loopback_lab.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module loopback_lab
    import board_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`KEY_BITS - 1:0]   key,        // Active high here
    input  logic [`SW_BITS - 1:0]    sw,
    input  logic [`MIC_BITS - 1:0]   mic_value,
    output logic [`SOUND_BITS - 1:0] sound,
    output seg_t                     abcdefgh,
    output digit_t                   digit
);

    localparam int SCAN_W = $clog2(`SCAN_DIV);
    localparam int IDX_W  = $clog2(`DIGITS);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`SCAN_DIV - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(`DIGITS - 1);

    logic signed [`SOUND_BITS - 1:0] top_word;
    logic signed [`SOUND_BITS - 1:0] shifted;    // Attenuated, sign kept
    logic [`MIC_BITS - 1:0]          disp;       // Frozen copy for the display
    logic [SCAN_W - 1:0]             scan_cnt;
    logic [IDX_W - 1:0]              scan_idx;   // 0 is the low nibble
    logic [3:0]                      nibble;

    // --------------------
    // Sound path

    assign top_word = mic_value[`MIC_BITS - 1 -: `SOUND_BITS];
    assign shifted  = top_word >>> sw;
    assign sound    = key[1] ? '0 : shifted;    // Mute wins

    // --------------------
    // Display scan

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            disp     <= '0;
            scan_cnt <= '0;
            scan_idx <= '0;
        end
        else
        begin
            if (!key[0])
                disp <= mic_value;            // Freeze while key 0 held

            if (scan_cnt == SCAN_LAST)
            begin
                scan_cnt <= '0;
                scan_idx <= (scan_idx == IDX_LAST) ? '0 : scan_idx + 1'b1;
            end
            else
            begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    assign digit  = digit_t'(1) << scan_idx;
    assign nibble = disp[scan_idx * 4 +: 4];

    // Hex font, abcdefgh with dp off
    always_comb
    begin
        case (nibble)
            4'h0: abcdefgh = 8'hfc;
            4'h1: abcdefgh = 8'h60;
            4'h2: abcdefgh = 8'hda;
            4'h3: abcdefgh = 8'hf2;
            4'h4: abcdefgh = 8'h66;
            4'h5: abcdefgh = 8'hb6;
            4'h6: abcdefgh = 8'hbe;
            4'h7: abcdefgh = 8'he0;
            4'h8: abcdefgh = 8'hfe;
            4'h9: abcdefgh = 8'hf6;
            4'ha: abcdefgh = 8'hee;
            4'hb: abcdefgh = 8'h3e;
            4'hc: abcdefgh = 8'h9c;
            4'hd: abcdefgh = 8'h7a;
            4'he: abcdefgh = 8'h9e;
            default: abcdefgh = 8'h8e;   // F
        endcase
    end

endmodule

/* verilog/i2s_audio_tx.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module i2s_audio_tx
    import board_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    i2s_timing_if.rx                 tim,
    input  logic                     load,
    input  logic [`SOUND_BITS - 1:0] sound,
    output logic                     sdata
);

    localparam bit_index_t SLOT_MASK = bit_index_t'(`I2S_SLOT_BITS - 1);

    logic [`SOUND_BITS - 1:0] word;       // Frame word, same for both slots
    logic [`SOUND_BITS - 1:0] shifter;    // Empties to zeros after 16 bits
    logic                     slot_start;

    // Slot bit 0 is the I2S delay bit
    assign slot_start = (tim.bit_index & SLOT_MASK) == '0;

    // --------------------
    // Serializer

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word    <= '0;
            shifter <= '0;
            sdata   <= 1'b0;
        end
        else
        begin
            if (load)
                word <= sound;                    // load coincides with frame_start

            if (tim.sck_fall)                     // sdata moves one clk after the fall
            begin
                if (slot_start)
                begin
                    sdata   <= 1'b0;
                    shifter <= load ? sound : word;   // Bypass on the loading fall
                end
                else
                begin
                    sdata   <= shifter[`SOUND_BITS - 1];
                    shifter <= {shifter[`SOUND_BITS - 2:0], 1'b0};
                end
            end
        end
    end

    // DAC samples while sck is high
    a_sdata_stable: assert property (@(posedge clk) disable iff (rst)
        tim.sck |-> $stable(sdata));

endmodule

/* verilog/inmp441_mic_receiver.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module inmp441_mic_receiver
    import board_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    i2s_timing_if.rx                 tim,
    input  logic                     sd,
    input  logic                     capture,
    output logic [`MIC_BITS - 1:0]   mic_value
);

    i2s_slot_u slot;    // Left slot, MSB first

    // --------------------
    // Shift in

    // Mic drives sd after the fall, so sample it on the rise
    always_ff @(posedge clk)
    begin
        if (tim.sck_rise && !tim.ws)
            slot.raw <= {slot.raw[$bits(slot.raw) - 2:0], sd};
    end

    // --------------------
    // Sample hold

    // After 32 rises the delay bit sits at the top of raw
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mic_value <= '0;
        else if (capture)
            mic_value <= slot.field.sample;   // Held until next frame
    end

endmodule

/* verilog/i2s_frame_fsm.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module i2s_frame_fsm
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    i2s_timing_if.rx tim,
    output logic capture,
    output logic load
);

    // First bit of the right slot
    localparam bit_index_t SLOT_END = bit_index_t'(`I2S_SLOT_BITS);

    typedef enum logic [1:0]
    {
        IDLE,     // Waiting for a whole frame
        LEFT,     // Mic word arriving
        RIGHT
    } state_t;

    state_t state;
    state_t state_next;
    logic   slot_boundary;

    // Fall that moves bit_index from 31 to 32
    assign slot_boundary = tim.sck_fall && (tim.bit_index == SLOT_END);

    // --------------------
    // Next state and strobes

    always_comb
    begin
        state_next = state;
        capture    = 1'b0;
        load       = 1'b0;

        case (state)
            IDLE:
            begin
                if (tim.frame_start)
                begin
                    state_next = LEFT;
                    load       = 1'b1;     // First full frame gets a fresh word too
                end
            end
            LEFT:
            begin
                if (slot_boundary)
                begin
                    state_next = RIGHT;
                    capture    = 1'b1;     // Left slot fully shifted in
                end
            end
            RIGHT:
            begin
                if (tim.frame_start)
                begin
                    state_next = LEFT;
                    load       = 1'b1;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    // Capture belongs to the left to right slot step, where ws rises
    a_capture_step: assert property (@(posedge clk) disable iff (rst)
        capture |-> $rose(tim.ws));

endmodule

/* verilog/i2s_clock_timer.sv */
`timescale 1ns/1ps

`include "board_params.svh"

module i2s_clock_timer
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    i2s_timing_if.tmr tim
);

    localparam int                HALF_W    = $clog2(`I2S_SCK_HALF);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`I2S_SCK_HALF - 1);
    localparam bit_index_t        BIT_LAST  = bit_index_t'(`I2S_FRAME_BITS - 1);

    logic [HALF_W - 1:0] half_cnt;    // clk cycles within half period
    logic                sck_q;
    logic                rise_q;
    logic                fall_q;
    logic                frame_q;
    bit_index_t          bit_cnt;

    // --------------------
    // Divider and bit counter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            half_cnt <= '0;
            sck_q    <= 1'b0;
            rise_q   <= 1'b0;
            fall_q   <= 1'b0;
            frame_q  <= 1'b0;
            bit_cnt  <= '0;
        end
        else
        begin
            rise_q  <= 1'b0;                      // Strobes last one clk
            fall_q  <= 1'b0;
            frame_q <= 1'b0;

            if (half_cnt == HALF_LAST)
            begin
                half_cnt <= '0;
                sck_q    <= ~sck_q;

                if (sck_q)                        // High now, so this is a fall
                begin
                    fall_q  <= 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;    // Wraps 63 to 0
                    frame_q <= (bit_cnt == BIT_LAST);
                end
                else
                begin
                    rise_q  <= 1'b1;
                end
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    assign tim.sck         = sck_q;
    assign tim.sck_rise    = rise_q;     // Registered next to sck, so aligned
    assign tim.sck_fall    = fall_q;
    assign tim.bit_index   = bit_cnt;
    assign tim.ws          = bit_cnt[$bits(bit_cnt) - 1];   // Flips with sck fall
    assign tim.frame_start = frame_q;

    a_edges_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rise_q && fall_q));

endmodule

/* verilog/i2s_timing_if.sv */
`timescale 1ns/1ps

interface i2s_timing_if
    import board_pkg::*;
();

    logic       sck;           // Bit clock level
    logic       ws;            // Low in the left slot
    logic       sck_rise;      // One clk, same cycle sck goes high
    logic       sck_fall;      // One clk, same cycle sck goes low
    bit_index_t bit_index;     // 0 to 63, moves on sck_fall
    logic       frame_start;   // sck_fall where bit_index wraps to 0

    // Single driver
    modport tmr (output sck, ws, sck_rise, sck_fall, bit_index, frame_start);

    // Frame FSM, receiver, transmitter
    modport rx  (input  sck, ws, sck_rise, sck_fall, bit_index, frame_start);

endinterface

/* verilog/board_pkg.sv */
`include "board_params.svh"

package board_pkg;

    // --------------------
    // I2S slot views

    // Position of sck inside a frame
    typedef logic [`I2S_INDEX_BITS - 1:0] bit_index_t;

    // Left slot as it arrives MSB first
    typedef struct packed
    {
        logic                                       delay;   // I2S one-bit delay
        logic [`MIC_BITS - 1:0]                     sample;
        logic [`I2S_SLOT_BITS - `MIC_BITS - 2:0]    pad;     // Trailing zeros
    } i2s_slot_s;

    typedef union packed
    {
        logic [`I2S_SLOT_BITS - 1:0] raw;      // Shift register view
        i2s_slot_s                   field;    // Decoded view
    } i2s_slot_u;

    // --------------------
    // Seven-segment

    typedef logic [7:0]           seg_t;      // abcdefgh, active high
    typedef logic [`DIGITS - 1:0] digit_t;    // One-hot digit select

endpackage

/* verilog/board_params.svh */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// --------------------
// I2S timing

`define I2S_SCK_HALF     8    // clk cycles per half sck period
`define I2S_SLOT_BITS    32   // Bits per slot
`define I2S_FRAME_BITS   64   // Left plus right slot
`define I2S_INDEX_BITS   6    // Bit index inside one frame

// --------------------
// Sample widths

`define MIC_BITS         24   // INMP441 word
`define SOUND_BITS       16   // Speaker DAC word

// --------------------
// Board controls and display

`define KEY_BITS         2
`define SW_BITS          3    // Attenuation shift amount
`define DIGITS           6
`define SCAN_DIV         4    // clk cycles per scanned digit

`endif
